//--- filelist.f
verilog/fm_pkg.sv
verilog/fm_host_port.sv
verilog/fm_slot_regs.sv
verilog/fm_keyon.sv
verilog/fm_alg_route.sv
verilog/fm_reg_top.sv
verification/fm_reg_assertions.sv
verification/fm_reg_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fm_reg_tb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	! grep -q "TEST FAIL" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/fm_reg_tb.sv
// Table-driven testbench for the FM register block, run as the simulation top with the file list
module fm_reg_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NTEST = 12;
	localparam int F_NONE = 0, F_CH_CTL = 1, F_KC = 2, F_KF = 3, F_DT1_MUL = 4;
	localparam int F_TL = 5, F_KS_AR = 6, F_AMS_D1R = 7, F_DT2_D2R = 8, F_D1L_RR = 9;

	logic clk = 1'b0;
	logic rst, wb_cyc, wb_stb, wb_we, wb_ack;
	logic [7:0] wb_adr, wb_dat_w, wb_dat_r;
	logic [4:0] slot;
	logic frame_start, ams_en, keyon, carrier, fb_en;
	logic [1:0] rl, ks, dt2;
	logic [2:0] fb, con, dt1;
	logic [6:0] kc, tl;
	logic [5:0] kf;
	logic [3:0] mul, d1l, rr;
	logic [4:0] ar, d1r, d2r;

	int errors = 0;
	int checks = 0;
	int seed = 32'h19e2_6d87;
	bit hung = 1'b0;

	// Address, data written, readback, stream field group and its expected value
	logic [7:0] t_adr [NTEST] = '{8'h21, 8'h2A, 8'h33, 8'h45, 8'h6C, 8'h91,
		8'hB4, 8'hDE, 8'hFF, 8'h07, 8'h08, 8'h38};
	logic [7:0] t_dat [NTEST] = '{8'hD5, 8'hC7, 8'hAD, 8'h3A, 8'hFF, 8'hA6,
		8'h9C, 8'h7B, 8'h5E, 8'h55, 8'h00, 8'hAA};
	logic [7:0] t_rd [NTEST] = '{8'hD5, 8'hC7, 8'hAD, 8'h3A, 8'hFF, 8'hA6,
		8'h9C, 8'h7B, 8'h5E, 8'h00, 8'h00, 8'h00};
	int t_fld [NTEST] = '{F_CH_CTL, F_KC, F_KF, F_DT1_MUL, F_TL, F_KS_AR, F_AMS_D1R,
		F_DT2_D2R, F_D1L_RR, F_NONE, F_NONE, F_NONE};
	int t_exp [NTEST] = '{'hD5, 'h47, 'h2B, 'h3A, 'h7F, 'h46, 'h3C, 'h3B, 'h5E, 0, 0, 0};

	fm_reg_top uut (.*);

	always #5 clk = ~clk;

	task automatic check(input string name, input int exp, input int act);
		if (!hung) begin
			checks++;
			if (exp != act) begin
				errors++;
				$display("** Error %s: expected %0h, actual %0h", name, exp, act);
			end
		end
	endtask

	task automatic report(input string name, input int err_before);
		$display("%s: %s", name, (errors == err_before && !hung) ? "ok" : "errors");
	endtask

	task automatic wait_slot(input int s);
		int n;
		n = 0;
		while (!hung && int'(slot) != s) begin
			@(negedge clk);
			n++;
			if (n > 40) begin
				hung = 1'b1;
				$display("Slot %0d never appeared on the stream", s);
			end
		end
	endtask

	task automatic wb_access(input logic we, input logic [7:0] adr, input logic [7:0] dat,
		output logic [7:0] rd);
		int n;
		n = 0;
		rd = 8'h00;
		if (!hung) begin
			wb_cyc = 1'b1;
			wb_stb = 1'b1;
			wb_we = we;
			wb_adr = adr;
			wb_dat_w = dat;
			do begin
				@(negedge clk);
				n++;
			end while (!wb_ack && n < 64);
			rd = wb_dat_r;                // Valid in the ack cycle
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we = 1'b0;
			if (!wb_ack) begin
				hung = 1'b1;
				$display("No acknowledge for access to address %h", adr);
			end else if (n > 35) begin
				errors++;
				$display("Access to address %h took %0d cycles", adr, n);
			end
			@(negedge clk);               // Strobe stays low for the cycle after ack
		end
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [7:0] adr, output logic [7:0] rd);
		wb_access(1'b0, adr, 8'h00, rd);
	endtask

	// All fields of one register group, packed in register bit order
	function automatic int field_val(input int f);
		case (f)
			F_CH_CTL:  return int'({rl, fb, con});
			F_KC:      return int'(kc);
			F_KF:      return int'(kf);
			F_DT1_MUL: return int'({dt1, mul});
			F_TL:      return int'(tl);
			F_KS_AR:   return int'({ks, ar});
			F_AMS_D1R: return int'({ams_en, d1r});
			F_DT2_D2R: return int'({dt2, d2r});
			F_D1L_RR:  return int'({d1l, rr});
			default:   return 0;
		endcase
	endfunction

	// YM2151 carrier set per connection, bit k for operator k
	function automatic logic [3:0] carrier_set(input int c);
		case (c)
			4:       return 4'b1100;
			5, 6:    return 4'b1110;
			7:       return 4'b1111;
			default: return 4'b1000;
		endcase
	endfunction

	task automatic scan_keyon(input logic [7:0] kon);
		wait_slot(0);
		for (int s = 0; s < 32; s++) begin
			check("keyon", int'((s % 8) == int'(kon[2:0]) && kon[3 + s / 8]), int'(keyon));
			@(negedge clk);
		end
	endtask

	initial begin
		int e0;
		logic [7:0] rd;
		logic [7:0] a, b, c, d;
		logic [3:0] cset;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 8'h00;
		wb_dat_w = 8'h00;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		wait_slot(0);                         // First frame_start

		e0 = errors;
		for (int i = 0; i < 64; i++) begin    // Clear walk frame, then the cleared memories
			check("reset slot", i % 32, int'(slot));
			check("reset frame_start", int'(i % 32 == 0), int'(frame_start));
			check("reset params", 0, int'(|{rl, fb, con, kc, kf, dt1, mul, tl, ks, ar,
				ams_en, d1r, dt2, d2r, d1l, rr}));
			check("reset keyon", 0, int'(keyon));
			@(negedge clk);
		end
		report("reset frame", e0);

		e0 = errors;
		for (int i = 0; i < NTEST; i++) begin
			wb_write(t_adr[i], t_dat[i]);
			wb_read(t_adr[i], rd);
			check($sformatf("readback %h", t_adr[i]), int'(t_rd[i]), int'(rd));
		end
		report("write and readback", e0);

		e0 = errors;
		for (int i = 0; i < NTEST; i++) begin
			if (t_fld[i] != F_NONE && t_adr[i] < 8'h40) begin
				for (int op = 0; op < 4; op++) begin
					wait_slot(op * 8 + int'(t_adr[i][2:0]));
					check($sformatf("stream %h", t_adr[i]), t_exp[i], field_val(t_fld[i]));
				end
			end else if (t_fld[i] != F_NONE) begin
				wait_slot(int'(t_adr[i][4:0]));
				check($sformatf("stream %h", t_adr[i]), t_exp[i], field_val(t_fld[i]));
			end
		end
		report("stream fields", e0);

		e0 = errors;
		wb_write(8'h08, 8'h56);               // Mask 1010 on channel 6
		scan_keyon(8'h56);
		wb_write(8'h08, 8'h06);
		scan_keyon(8'h06);
		report("key-on", e0);

		e0 = errors;
		for (int cn = 0; cn < 8; cn++) begin
			wb_write(8'h24, {2'b11, 3'd3, 3'(cn)});
			cset = carrier_set(cn);
			for (int op = 0; op < 4; op++) begin
				wait_slot(op * 8 + 4);
				check($sformatf("carrier con %0d op %0d", cn, op),
					int'(cset[op]), int'(carrier));
				check($sformatf("fb_en con %0d op %0d", cn, op), int'(op == 0), int'(fb_en));
			end
		end
		report("algorithm routing", e0);

		e0 = errors;
		a = 8'($random(seed));
		b = 8'($random(seed));
		c = 8'($random(seed));
		d = 8'($random(seed));
		wb_write(8'h65, a);
		wb_write(8'h67, b);
		wb_write(8'h66, c);
		wb_write(8'h66, d);
		wb_read(8'h66, rd);
		check("overwrite readback", int'(d), int'(rd));
		wb_read(8'h65, rd);
		check("neighbour readback", int'(a), int'(rd));
		wait_slot(5);
		check("tl slot 5", int'(a[6:0]), int'(tl));
		@(negedge clk);
		check("tl slot 6", int'(d[6:0]), int'(tl));
		@(negedge clk);
		check("tl slot 7", int'(b[6:0]), int'(tl));
		report("overwrite", e0);

		$display("Checks %0d, errors %0d, timeout %0d", checks, errors, int'(hung));
		if (hung || errors != 0)
			$display("TEST FAIL");
		else
			$display("TEST PASS");
		$finish;
	end

endmodule

//--- verification/fm_reg_assertions.sv
// Concurrent checks on the Wishbone handshake and slot counter, bound into the FM register top level
module fm_reg_assertions (
	input logic       clk,
	input logic       rst,
	input logic       wb_cyc,
	input logic       wb_stb,
	input logic       wb_ack,
	input logic [4:0] slot,
	input logic       frame_start
);
	timeunit 1ns;
	timeprecision 1ps;

	ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else $error("wb_ack held longer than one cycle");

	ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))   // Ack only answers an open cycle
		else $error("wb_ack without an active bus cycle");

	slot_step: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> slot == 5'($past(slot) + 5'd1))     // Wraps after 31
		else $error("Slot counter did not advance by one");

	frame_mark: assert property (@(posedge clk) disable iff (rst)
		frame_start == (slot == 5'd0))
		else $error("frame_start out of step with slot 0");

endmodule

bind fm_reg_top fm_reg_assertions u_assert (
	.clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
	.slot(slot), .frame_start(frame_start)
);

//--- verilog/fm_reg_top.sv
// Top level of the FM register block: Wishbone host port, slot register memories, key-on and router
module fm_reg_top
	import fm_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [7:0]        wb_adr,
	input  logic [7:0]        wb_dat_w,
	output logic [7:0]        wb_dat_r,
	output logic              wb_ack,
	output logic [SLOT_W-1:0] slot,
	output logic              frame_start,
	output logic [1:0]        rl,
	output logic [2:0]        fb,
	output logic [2:0]        con,
	output logic [6:0]        kc,
	output logic [5:0]        kf,
	output logic [2:0]        dt1,
	output logic [3:0]        mul,
	output logic [6:0]        tl,
	output logic [1:0]        ks,
	output logic [4:0]        ar,
	output logic              ams_en,
	output logic [4:0]        d1r,
	output logic [1:0]        dt2,
	output logic [4:0]        d2r,
	output logic [3:0]        d1l,
	output logic [3:0]        rr,
	output logic              keyon,
	output logic              carrier,
	output logic              fb_en
);

	logic              req_valid;
	logic              req_we;
	logic [GRP_W-1:0]  req_grp;
	logic [SLOT_W-1:0] req_idx;
	fm_reg_byte        req_data;
	logic              req_done;
	logic [7:0]        req_rdata;
	logic              keyon_done;

	fm_host_port u_host (
		.clk(clk), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.req_valid(req_valid), .req_we(req_we), .req_grp(req_grp), .req_idx(req_idx),
		.req_data(req_data), .req_done(req_done), .req_rdata(req_rdata),
		.keyon_done(keyon_done)
	);

	fm_slot_regs u_regs (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_we(req_we), .req_grp(req_grp), .req_idx(req_idx),
		.req_data(req_data), .req_done(req_done), .req_rdata(req_rdata),
		.slot(slot), .frame_start(frame_start),
		.rl(rl), .fb(fb), .con(con), .kc(kc), .kf(kf),
		.dt1(dt1), .mul(mul), .tl(tl), .ks(ks), .ar(ar), .ams_en(ams_en),
		.d1r(d1r), .dt2(dt2), .d2r(d2r), .d1l(d1l), .rr(rr)
	);

	fm_keyon u_keyon (
		.clk(clk), .rst(rst),
		.req_valid(req_valid), .req_we(req_we), .req_grp(req_grp), .req_data(req_data),
		.slot(slot), .keyon(keyon), .keyon_done(keyon_done)
	);

	fm_alg_route u_route (
		.con(con), .fb(fb), .slot(slot),
		.carrier(carrier), .fb_en(fb_en)
	);

endmodule

//--- verilog/fm_alg_route.sv
// Carrier and self-feedback flags for the streamed slot from its channel's connection algorithm
module fm_alg_route
	import fm_pkg::*;
(
	input  logic [2:0]        con,
	input  logic [2:0]        fb,
	input  logic [SLOT_W-1:0] slot,
	output logic              carrier,
	output logic              fb_en
);

	logic [1:0] op;

	assign op = slot[SLOT_W-1:CH_W];

	// C2 always reaches the output; the others join as the algorithm number grows
	always_comb begin
		case (op)
			OP_C2:   carrier = 1'b1;
			OP_C1:   carrier = (con >= 3'd4);
			OP_M2:   carrier = (con >= 3'd5);
			default: carrier = (con == 3'd7);   // M1
		endcase
	end

	assign fb_en = (op == OP_M1) && (fb != 3'd0); // Only M1 feeds back on itself

endmodule

//--- verilog/fm_keyon.sv
// Per-slot key-on memory written by the key-on register and streamed in step with the slot counter
module fm_keyon
	import fm_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	input  logic              req_we,
	input  logic [GRP_W-1:0]  req_grp,
	input  fm_reg_byte        req_data,
	input  logic [SLOT_W-1:0] slot,
	output logic              keyon,
	output logic              keyon_done
);

	logic [NUM_SLOT-1:0] kon_bits;
	logic [SLOT_W-1:0]   slot_next;
	logic                kon_wr;

	assign slot_next = slot + 1'b1;           // Wraps 31 to 0
	assign kon_wr    = req_valid && req_we && (req_grp == GRP_KEYON) && !keyon_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			kon_bits   <= '0;
			keyon      <= 1'b0;
			keyon_done <= 1'b0;
		end else begin
			keyon_done <= kon_wr;
			keyon      <= kon_bits[slot_next]; // Lines up with slot next cycle
			if (kon_wr) begin
				// Mask bit k drives operator k, unmasked operators key off
				for (int k = 0; k < NUM_OP; k++)
					kon_bits[{2'(k), req_data.keyon.ch}] <= req_data.keyon.op_mask[k];
			end
		end
	end

endmodule

//--- verilog/fm_slot_regs.sv
// Slot counter and channel/operator register memories streaming one slot's parameters per clock
module fm_slot_regs
	import fm_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              req_valid,
	input  logic              req_we,
	input  logic [GRP_W-1:0]  req_grp,
	input  logic [SLOT_W-1:0] req_idx,
	input  fm_reg_byte        req_data,
	output logic              req_done,
	output logic [7:0]        req_rdata,
	output logic [SLOT_W-1:0] slot,
	output logic              frame_start,
	output logic [1:0]        rl,
	output logic [2:0]        fb,
	output logic [2:0]        con,
	output logic [6:0]        kc,
	output logic [5:0]        kf,
	output logic [2:0]        dt1,
	output logic [3:0]        mul,
	output logic [6:0]        tl,
	output logic [1:0]        ks,
	output logic [4:0]        ar,
	output logic              ams_en,
	output logic [4:0]        d1r,
	output logic [1:0]        dt2,
	output logic [4:0]        d2r,
	output logic [3:0]        d1l,
	output logic [3:0]        rr
);

	logic [OP_BYTES-1:0][7:0] op_mem [NUM_SLOT];
	logic [CH_BYTES-1:0][7:0] ch_mem [NUM_CH];
	logic [OP_BYTES-1:0][7:0] op_q;
	logic [CH_BYTES-1:0][7:0] ch_q;

	logic [SLOT_W-1:0] cnt;                   // Slot being accessed, one ahead of the stream
	logic [CH_W-1:0]   cnt_ch;
	logic              clr;                   // Clear walk in progress
	logic              is_op;
	logic              is_ch;
	logic              hit;
	logic [2:0]        op_sel;
	logic [1:0]        ch_sel;

	fm_reg_byte ch_ctl_b;
	fm_reg_byte kc_b;
	fm_reg_byte kf_b;
	fm_reg_byte dt1_b;
	fm_reg_byte tl_b;
	fm_reg_byte ks_b;
	fm_reg_byte ams_b;
	fm_reg_byte dt2_b;
	fm_reg_byte d1l_b;

	assign cnt_ch = cnt[CH_W-1:0];
	assign op_sel = 3'(req_grp - GRP_OP0);
	assign ch_sel = 2'(req_grp - GRP_CH_CTL);
	assign is_op  = (req_grp >= GRP_OP0) && (req_grp <= GRP_OP5);
	assign is_ch  = (req_grp >= GRP_CH_CTL) && (req_grp <= GRP_KF);

	// Channel groups hit on the first slot of any operator in that channel
	assign hit = req_valid && !req_done && !clr &&
		((is_op && cnt == req_idx) || (is_ch && cnt_ch == req_idx[CH_W-1:0]));

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt         <= SLOT_W'(1);        // Stream shows slot 0 first
			slot        <= '0;
			frame_start <= 1'b1;
			clr         <= 1'b1;
			req_done    <= 1'b0;
		end else begin
			cnt         <= cnt + 1'b1;
			slot        <= cnt;
			frame_start <= (cnt == '0);
			req_done    <= hit;
			if (cnt == '0)
				clr <= 1'b0;                  // Walk has covered all 32 entries
		end
	end

	always_ff @(posedge clk) begin
		if (clr) begin
			op_mem[cnt]    <= '0;
			ch_mem[cnt_ch] <= '0;
		end else if (hit && req_we) begin
			if (is_op)
				op_mem[cnt][op_sel] <= req_data.raw;
			else
				ch_mem[cnt_ch][ch_sel] <= req_data.raw;
		end
		if (hit)
			req_rdata <= is_op ? op_mem[cnt][op_sel] : ch_mem[cnt_ch][ch_sel];
	end

	// Stream registers, old contents read when a write hits the same slot
	always_ff @(posedge clk) begin
		if (rst || clr) begin
			op_q <= '0;
			ch_q <= '0;
		end else begin
			op_q <= op_mem[cnt];
			ch_q <= ch_mem[cnt_ch];
		end
	end

	assign ch_ctl_b = ch_q[0];
	assign kc_b     = ch_q[1];
	assign kf_b     = ch_q[2];
	assign dt1_b    = op_q[0];
	assign tl_b     = op_q[1];
	assign ks_b     = op_q[2];
	assign ams_b    = op_q[3];
	assign dt2_b    = op_q[4];
	assign d1l_b    = op_q[5];

	assign rl     = ch_ctl_b.ch_ctl.rl;
	assign fb     = ch_ctl_b.ch_ctl.fb;
	assign con    = ch_ctl_b.ch_ctl.con;
	assign kc     = kc_b.raw[6:0];
	assign kf     = kf_b.raw[7:2];            // Fraction sits in the top six bits
	assign dt1    = dt1_b.dt1_mul.dt1;
	assign mul    = dt1_b.dt1_mul.mul;
	assign tl     = tl_b.raw[6:0];
	assign ks     = ks_b.ks_ar.ks;
	assign ar     = ks_b.ks_ar.ar;
	assign ams_en = ams_b.raw[7];
	assign d1r    = ams_b.ks_ar.ar;           // Same low five bits as AR
	assign dt2    = dt2_b.ks_ar.ks;           // DT2/D2R split like KS/AR
	assign d2r    = dt2_b.ks_ar.ar;
	assign d1l    = d1l_b.d1l_rr.d1l;
	assign rr     = d1l_b.d1l_rr.rr;

endmodule

//--- verilog/fm_host_port.sv
// Wishbone classic slave turning host register accesses into slot requests for the register memories
module fm_host_port
	import fm_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [7:0]        wb_adr,
	input  logic [7:0]        wb_dat_w,
	output logic [7:0]        wb_dat_r,
	output logic              wb_ack,
	output logic              req_valid,
	output logic              req_we,
	output logic [GRP_W-1:0]  req_grp,
	output logic [SLOT_W-1:0] req_idx,
	output fm_reg_byte        req_data,
	input  logic              req_done,
	input  logic [7:0]        req_rdata,
	input  logic              keyon_done
);

	logic [ST_W-1:0]   state;
	logic [GRP_W-1:0]  dec_grp;
	logic [SLOT_W-1:0] dec_idx;
	logic              fast_path;
	logic              fast;
	logic              done;

	always_comb begin
		dec_grp = GRP_NONE;
		dec_idx = {2'b00, wb_adr[2:0]};       // Channel groups index by channel
		case ({wb_adr[7:5], 5'b00000})
			REG_DT1_MUL: dec_grp = GRP_OP0;
			REG_TL:      dec_grp = GRP_OP1;
			REG_KS_AR:   dec_grp = GRP_OP2;
			REG_AMS_D1R: dec_grp = GRP_OP3;
			REG_DT2_D2R: dec_grp = GRP_OP4;
			REG_D1L_RR:  dec_grp = GRP_OP5;
			default: begin
				case ({wb_adr[7:3], 3'b000})
					REG_CH_CTL: dec_grp = GRP_CH_CTL;
					REG_KC:     dec_grp = GRP_KC;
					REG_KF:     dec_grp = GRP_KF;
					default:    dec_grp = (wb_adr == REG_KEYON) ? GRP_KEYON : GRP_NONE;
				endcase
			end
		endcase
		if (dec_grp >= GRP_OP0)
			dec_idx = wb_adr[4:0];            // Operator groups index by slot
	end

	// Unmapped addresses and key-on reads never reach the memories
	assign fast_path = (dec_grp == GRP_NONE) || (dec_grp == GRP_KEYON && !wb_we);
	assign done      = fast || req_done || keyon_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_IDLE;
			req_valid <= 1'b0;
			fast      <= 1'b0;
			wb_ack    <= 1'b0;
		end else begin
			wb_ack <= 1'b0;
			case (state)
				ST_IDLE: if (wb_cyc && wb_stb) begin
					state     <= ST_PEND;
					fast      <= fast_path;
					req_valid <= !fast_path;
				end
				ST_PEND: if (done) begin
					state     <= ST_ACK;
					fast      <= 1'b0;
					req_valid <= 1'b0;
					wb_ack    <= 1'b1;
				end
				default: state <= ST_IDLE;    // ACK lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE) begin           // Held steady until the request completes
			req_we       <= wb_we;
			req_grp      <= dec_grp;
			req_idx      <= dec_idx;
			req_data.raw <= wb_dat_w;
		end
		if (state == ST_PEND && done)
			wb_dat_r <= (req_done && !req_we) ? req_rdata : 8'h00;
	end

endmodule

//--- verilog/fm_pkg.sv
// Shared register map, slot geometry and data-byte layouts, imported by every FM register module
package fm_pkg;

	localparam int NUM_CH   = 8;
	localparam int NUM_OP   = 4;
	localparam int NUM_SLOT = 32;
	localparam int CH_W     = 3;              // Channel part of a slot number
	localparam int SLOT_W   = 5;              // {operator, channel}
	localparam int OP_BYTES = 6;              // Raw bytes stored per operator slot
	localparam int CH_BYTES = 3;              // Raw bytes stored per channel

	// Host register map
	localparam logic [7:0] REG_KEYON   = 8'h08;
	localparam logic [7:0] REG_CH_CTL  = 8'h20;
	localparam logic [7:0] REG_KC      = 8'h28;
	localparam logic [7:0] REG_KF      = 8'h30;
	localparam logic [7:0] REG_DT1_MUL = 8'h40;
	localparam logic [7:0] REG_TL      = 8'h60;
	localparam logic [7:0] REG_KS_AR   = 8'h80;
	localparam logic [7:0] REG_AMS_D1R = 8'hA0;
	localparam logic [7:0] REG_DT2_D2R = 8'hC0;
	localparam logic [7:0] REG_D1L_RR  = 8'hE0;

	// Register group codes on the internal request path
	localparam int GRP_W = 4;
	localparam logic [GRP_W-1:0] GRP_NONE   = 4'd0;
	localparam logic [GRP_W-1:0] GRP_KEYON  = 4'd1;
	localparam logic [GRP_W-1:0] GRP_CH_CTL = 4'd2;
	localparam logic [GRP_W-1:0] GRP_KC     = 4'd3;
	localparam logic [GRP_W-1:0] GRP_KF     = 4'd4;
	localparam logic [GRP_W-1:0] GRP_OP0    = 4'd5;   // DT1/MUL
	localparam logic [GRP_W-1:0] GRP_OP1    = 4'd6;   // TL
	localparam logic [GRP_W-1:0] GRP_OP2    = 4'd7;   // KS/AR
	localparam logic [GRP_W-1:0] GRP_OP3    = 4'd8;   // AMS-EN/D1R
	localparam logic [GRP_W-1:0] GRP_OP4    = 4'd9;   // DT2/D2R
	localparam logic [GRP_W-1:0] GRP_OP5    = 4'd10;  // D1L/RR

	// Operator position in the upper slot bits
	localparam logic [1:0] OP_M1 = 2'd0;
	localparam logic [1:0] OP_M2 = 2'd1;
	localparam logic [1:0] OP_C1 = 2'd2;
	localparam logic [1:0] OP_C2 = 2'd3;

	// Host port handshake states
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
	localparam logic [ST_W-1:0] ST_PEND = 2'd1;
	localparam logic [ST_W-1:0] ST_ACK  = 2'd2;

	// One data byte, decoded by register address
	typedef union packed {
		logic [7:0] raw;
		struct packed { logic [1:0] rl; logic [2:0] fb; logic [2:0] con; } ch_ctl;
		struct packed { logic spare; logic [3:0] op_mask; logic [2:0] ch; } keyon;
		struct packed { logic spare; logic [2:0] dt1; logic [3:0] mul; } dt1_mul;
		struct packed { logic [1:0] ks; logic spare; logic [4:0] ar; } ks_ar;
		struct packed { logic [3:0] d1l; logic [3:0] rr; } d1l_rr;
	} fm_reg_byte;

endpackage
